/* dv/axi_mem_chk.sv */
// Protocol assertions for the AXI to uncached memory bridge.
// Bound into axi_mem_top, so it sees the AXI ports and the internal stream links.
// Any violation is reported through $error.
`timescale 1ns/1ps

module axi_mem_chk
  (input         clk_i
   , input       reset_i
   , input       awvalid_i
   , input       awready_i
   , input [7:0] awlen_i
   , input       wvalid_i
   , input       wready_i
   , input       arvalid_i
   , input       arready_i
   , input [7:0] arlen_i
   , input       bvalid_i
   , input       bready_i
   , input       rvalid_i
   , input       rready_i
   , input       req_v_i
   , input       req_ready_i
   , input       rsp_v_i
   , input       rsp_ready_i
   , input       fwd_v_i
   , input       fwd_ready_i
   , input       rev_v_i
   , input       rev_ready_i
   );

  // Single beat only.
  aw_len_a: assert property (@(posedge clk_i) disable iff (reset_i)
    awvalid_i |-> awlen_i == 8'd0) else $error("awlen is not zero");
  ar_len_a: assert property (@(posedge clk_i) disable iff (reset_i)
    arvalid_i |-> arlen_i == 8'd0) else $error("arlen is not zero");

  aw_hold_a: assert property (@(posedge clk_i) disable iff (reset_i)
    awvalid_i && !awready_i |=> awvalid_i) else $error("awvalid dropped early");
  w_hold_a: assert property (@(posedge clk_i) disable iff (reset_i)
    wvalid_i && !wready_i |=> wvalid_i) else $error("wvalid dropped early");
  ar_hold_a: assert property (@(posedge clk_i) disable iff (reset_i)
    arvalid_i && !arready_i |=> arvalid_i) else $error("arvalid dropped early");
  b_hold_a: assert property (@(posedge clk_i) disable iff (reset_i)
    bvalid_i && !bready_i |=> bvalid_i) else $error("bvalid dropped early");
  r_hold_a: assert property (@(posedge clk_i) disable iff (reset_i)
    rvalid_i && !rready_i |=> rvalid_i) else $error("rvalid dropped early");
  req_hold_a: assert property (@(posedge clk_i) disable iff (reset_i)
    req_v_i && !req_ready_i |=> req_v_i) else $error("req_v dropped early");
  rsp_hold_a: assert property (@(posedge clk_i) disable iff (reset_i)
    rsp_v_i && !rsp_ready_i |=> rsp_v_i) else $error("rsp_v dropped early");
  fwd_hold_a: assert property (@(posedge clk_i) disable iff (reset_i)
    fwd_v_i && !fwd_ready_i |=> fwd_v_i) else $error("mem_fwd_v dropped early");
  rev_hold_a: assert property (@(posedge clk_i) disable iff (reset_i)
    rev_v_i && !rev_ready_i |=> rev_v_i) else $error("mem_rev_v dropped early");

  // Endpoint answers exactly one cycle after it accepts a message.
  rev_lat_a: assert property (@(posedge clk_i) disable iff (reset_i)
    fwd_v_i && fwd_ready_i |=> rev_v_i) else $error("endpoint response late");
  rev_cause_a: assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(rev_v_i) |-> $past(fwd_v_i && fwd_ready_i)) else $error("response without request");

  reset_quiet_a: assert property (@(posedge clk_i) reset_i && $past(reset_i) |->
    !(bvalid_i || rvalid_i || req_v_i || rsp_v_i || fwd_v_i || rev_v_i
      || awready_i || wready_i || arready_i)) else $error("valid or ready high in reset");

endmodule

bind axi_mem_top axi_mem_chk chk_i
  (.clk_i(clk_i), .reset_i(reset_i)
   ,.awvalid_i(awvalid_i), .awready_i(awready_o), .awlen_i(awlen_i)
   ,.wvalid_i(wvalid_i), .wready_i(wready_o)
   ,.arvalid_i(arvalid_i), .arready_i(arready_o), .arlen_i(arlen_i)
   ,.bvalid_i(bvalid_o), .bready_i(bready_i), .rvalid_i(rvalid_o), .rready_i(rready_i)
   ,.req_v_i(req_v), .req_ready_i(req_ready_and), .rsp_v_i(rsp_v), .rsp_ready_i(rsp_ready_and)
   ,.fwd_v_i(mem_fwd_v), .fwd_ready_i(mem_fwd_ready_and)
   ,.rev_v_i(mem_rev_v), .rev_ready_i(mem_rev_ready_and)
   );

/* dv/axi_mem_tb.sv */
// Testbench for the AXI to uncached memory bridge.
// Drives single-beat AXI writes and reads on the falling edge, keeps a reference
// memory, and checks every B and R handshake against it. Directed tests come
// first, then random read/write pairs with random ready gaps.
`timescale 1ns/1ps
`include "axi_mem_cfg.svh"

module axi_mem_tb;

  localparam int clk_half_lp     = 4;
  localparam int reset_cycles_lp = 10;
  localparam int rand_pairs_lp   = 200;
  localparam int txn_count_lp    = 2 * rand_pairs_lp + 24;
  localparam int txn_cycles_lp   = 60;                   // Generous bound per transaction.
  localparam int timeout_ns_lp   = (txn_count_lp * txn_cycles_lp + 100) * 2 * clk_half_lp;

  logic clk_i = 1'b0;
  logic reset_i;
  logic [`AXI_MEM_LCE_ID_W-1:0] lce_id_i;
  logic [`AXI_MEM_DID_W-1:0]    did_i;
  logic [`AXI_MEM_ADDR_W-1:0]   awaddr_i, araddr_i;
  logic [`AXI_MEM_ID_W-1:0]     awid_i, arid_i, bid_o, rid_o;
  logic [7:0]                   awlen_i, arlen_i;
  logic [2:0]                   awsize_i, arsize_i;
  logic                         awvalid_i, awready_o, wlast_i, wvalid_i, wready_o;
  logic [`AXI_MEM_DATA_W-1:0]   wdata_i, rdata_o;
  logic [1:0]                   bresp_o, rresp_o;
  logic                         bvalid_o, bready_i, arvalid_i, arready_o;
  logic                         rlast_o, rvalid_o, rready_i;

  logic [63:0] ref_mem [`AXI_MEM_WORDS];
  logic [1:0]  exp_b_id [$];
  logic [1:0]  exp_r_id [$];
  logic [63:0] exp_r_data [$];
  int          error_count = 0;
  int          wr_issued = 0, rd_issued = 0, b_count = 0, r_count = 0;
  logic [15:0] stim_lfsr = 16'd79;
  logic [15:0] gap_lfsr = 16'd79;
  logic        hold_ready = 1'b0, gaps_on = 1'b0;
  logic        b_hold = 1'b0, r_hold = 1'b0;
  logic [1:0]  b_prev_id, r_prev_id;
  logic [63:0] r_prev_data;

  axi_mem_top axi_mem_top_i (.*);

  always #(clk_half_lp) clk_i = ~clk_i;

  // x^16 + x^14 + x^13 + x^11 + 1.
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      stim_lfsr = lfsr_step(stim_lfsr);
      v = {v[62:0], stim_lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic gap_bit();
    gap_lfsr = lfsr_step(gap_lfsr);
    return gap_lfsr[0];
  endfunction

  // Bytes off .. off + 2**size - 1 come from the write data.
  function automatic logic [63:0] ref_merge(input logic [63:0] old_word,
                                            input logic [63:0] wdata,
                                            input logic [2:0] off, input logic [2:0] size);
    logic [63:0] res;
    int          nbytes;
    res = old_word;
    nbytes = 1 << size;
    for (int b = 0; b < 8; b++) begin
      if (b >= int'(off) && b < int'(off) + nbytes) res[8*b +: 8] = wdata[8*b +: 8];
    end
    return res;
  endfunction

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
      error_count++;
    end
  endtask

  // order 0 sends AW and W together, 1 sends W first, 2 sends AW first.
  task automatic do_write(input logic [31:0] addr, input logic [2:0] size,
                          input logic [63:0] data, input logic [1:0] id, input int order);
    logic aw_done, w_done, aw_take, w_take;
    aw_done = 1'b0;
    w_done = 1'b0;
    ref_mem[addr[10:3]] = ref_merge(ref_mem[addr[10:3]], data, addr[2:0], size);
    exp_b_id.push_back(id);
    wr_issued++;
    @(negedge clk_i);
    awaddr_i = addr;
    awid_i = id;
    awsize_i = size;
    wdata_i = data;
    awvalid_i = (order != 1);
    wvalid_i = (order != 2);
    while (!(aw_done && w_done)) begin
      aw_take = awvalid_i && awready_o;            // Readies are stable mid-cycle.
      w_take = wvalid_i && wready_o;
      @(posedge clk_i);
      @(negedge clk_i);
      if (aw_take) aw_done = 1'b1;
      if (w_take) w_done = 1'b1;
      awvalid_i = !aw_done && (order != 1 || w_done);
      wvalid_i = !w_done && (order != 2 || aw_done);
    end
  endtask

  task automatic do_read(input logic [31:0] addr, input logic [2:0] size, input logic [1:0] id);
    logic ar_take;
    exp_r_id.push_back(id);
    exp_r_data.push_back(ref_mem[addr[10:3]]);   // Whole word comes back.
    rd_issued++;
    @(negedge clk_i);
    araddr_i = addr;
    arid_i = id;
    arsize_i = size;
    arvalid_i = 1'b1;
    ar_take = 1'b0;
    while (!ar_take) begin
      ar_take = arready_o;
      @(posedge clk_i);
      @(negedge clk_i);
    end
    arvalid_i = 1'b0;
  endtask

  task automatic wait_done();
    wait (b_count == wr_issued && r_count == rd_issued);
    @(negedge clk_i);
  endtask

  // One write and one read to different words, each after a random gap.
  task automatic random_pair();
    logic [7:0]  wi, ri;
    logic [2:0]  wsize, rsize, woff;
    logic [63:0] wdata;
    logic [1:0]  wid, rid;
    int          order, wgap, rgap;
    wi = 8'(rand_bits(8));
    ri = 8'(rand_bits(8));
    if (ri == wi) ri = wi ^ 8'd1;
    wsize = 3'(rand_bits(2));
    woff = 3'(rand_bits(3)) & ~(3'((1 << wsize) - 1));   // Aligned to the size.
    rsize = 3'(rand_bits(2));
    wdata = rand_bits(64);
    wid = 2'(rand_bits(2));
    rid = 2'(rand_bits(2));
    order = int'(rand_bits(2)) % 3;
    wgap = int'(rand_bits(2));
    rgap = int'(rand_bits(2));
    fork
      begin
        repeat (wgap) @(negedge clk_i);
        do_write({21'd0, wi, woff}, wsize, wdata, wid, order);
      end
      begin
        repeat (rgap) @(negedge clk_i);
        do_read({21'd0, ri, 3'd0}, rsize, rid);
      end
    join
    wait_done();
  endtask

  // Drive the readies, then compare the handshake the next rising edge will take.
  // Valids and fields change only at the rising edge, so they are stable here.
  always @(negedge clk_i) begin
    if (hold_ready) begin
      bready_i = 1'b0;
      rready_i = 1'b0;
    end else if (gaps_on) begin
      bready_i = gap_bit() | gap_bit();                  // Ready three cycles in four.
      rready_i = gap_bit() | gap_bit();
    end else begin
      bready_i = 1'b1;
      rready_i = 1'b1;
    end
    if (!reset_i) begin
      if (b_hold) begin
        check_value("bvalid_o", bvalid_o, 64'd1);
        check_value("bid_o", bid_o, b_prev_id);
      end
      if (r_hold) begin
        check_value("rvalid_o", rvalid_o, 64'd1);
        check_value("rid_o", rid_o, r_prev_id);
        check_value("rdata_o", rdata_o, r_prev_data);
      end
      if (bvalid_o && bready_i) begin
        if (exp_b_id.size() == 0) begin
          $display("ERROR at %0t ns: write response with no write outstanding", $time);
          error_count++;
        end else begin
          check_value("bid_o", bid_o, exp_b_id.pop_front());
          check_value("bresp_o", bresp_o, 64'd0);
        end
        b_count++;
      end
      if (rvalid_o && rready_i) begin
        if (exp_r_id.size() == 0) begin
          $display("ERROR at %0t ns: read response with no read outstanding", $time);
          error_count++;
        end else begin
          check_value("rid_o", rid_o, exp_r_id.pop_front());
          check_value("rdata_o", rdata_o, exp_r_data.pop_front());
          check_value("rresp_o", rresp_o, 64'd0);
          check_value("rlast_o", rlast_o, 64'd1);
        end
        r_count++;
      end
      b_hold = bvalid_o && !bready_i;
      r_hold = rvalid_o && !rready_i;
      b_prev_id = bid_o;
      r_prev_id = rid_o;
      r_prev_data = rdata_o;
    end
  end

  initial begin
    #(timeout_ns_lp);
    $display("Timeout after %0d ns: a handshake or response never completed", timeout_ns_lp);
    $display("Regression failed");
    $finish;
  end

  initial begin
    logic [2:0] nsize, noff;
    for (int i = 0; i < `AXI_MEM_WORDS; i++) ref_mem[i] = '0;
    reset_i = 1'b1;
    lce_id_i = 4'h5;
    did_i = 3'h2;
    awaddr_i = '0;
    awid_i = '0;
    awlen_i = 8'd0;
    awsize_i = 3'd3;
    awvalid_i = 1'b0;
    wdata_i = '0;
    wlast_i = 1'b1;
    wvalid_i = 1'b0;
    bready_i = 1'b1;
    araddr_i = '0;
    arid_i = '0;
    arlen_i = 8'd0;
    arsize_i = 3'd3;
    arvalid_i = 1'b0;
    rready_i = 1'b1;

    repeat (5) @(negedge clk_i);
    check_value("awready_o", awready_o, 64'd0);
    check_value("wready_o", wready_o, 64'd0);
    check_value("arready_o", arready_o, 64'd0);
    check_value("bvalid_o", bvalid_o, 64'd0);
    check_value("rvalid_o", rvalid_o, 64'd0);
    repeat (reset_cycles_lp - 5) @(negedge clk_i);
    reset_i = 1'b0;
    repeat (2) @(negedge clk_i);
    check_value("awready_o", awready_o, 64'd1);
    check_value("wready_o", wready_o, 64'd1);
    check_value("arready_o", arready_o, 64'd1);

    // Full word written, then read back.
    do_write(32'h40, 3'd3, 64'h0123_4567_89ab_cdef, 2'd2, 0);
    wait_done();
    do_read(32'h40, 3'd3, 2'd1);
    wait_done();

    // Narrow writes merged into one word, read back after each.
    do_write(32'h88, 3'd3, 64'hfedc_ba98_7654_3210, 2'd0, 0);
    wait_done();
    for (int i = 0; i < 6; i++) begin
      nsize = 3'(i % 3);
      noff = 3'(rand_bits(3)) & ~(3'((1 << nsize) - 1));
      do_write(32'h88 | 32'(noff), nsize, rand_bits(64), 2'(i), i % 3);
      wait_done();
      do_read(32'h88, 3'd3, 2'(i + 1));
      wait_done();
    end

    // AW, W and AR together, then W ahead of AW.
    fork
      do_write(32'h100, 3'd3, 64'h1111_2222_3333_4444, 2'd3, 0);
      do_read(32'h40, 3'd3, 2'd0);
    join
    wait_done();
    fork
      do_write(32'h108, 3'd3, 64'h5555_6666_7777_8888, 2'd1, 1);
      do_read(32'h100, 3'd3, 2'd2);
    join
    wait_done();

    // Both responses stalled for a while.
    @(posedge clk_i);
    hold_ready = 1'b1;
    fork
      do_write(32'h110, 3'd2, 64'h9999_aaaa_bbbb_cccc, 2'd1, 0);
      do_read(32'h108, 3'd3, 2'd3);
    join
    wait (bvalid_o && rvalid_o);
    repeat (6) begin
      @(negedge clk_i);
      check_value("bvalid_o", bvalid_o, 64'd1);
      check_value("rvalid_o", rvalid_o, 64'd1);
    end
    @(posedge clk_i);
    hold_ready = 1'b0;
    wait_done();

    @(posedge clk_i);
    gaps_on = 1'b1;
    repeat (rand_pairs_lp) random_pair();

    if (exp_b_id.size() != 0 || exp_r_id.size() != 0) begin
      $display("ERROR: responses still missing at the end of the run");
      error_count++;
    end
    $display("Run complete with %0d errors", error_count);
    if (error_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* flist.f */
+incdir+src
src/axi_mem_pkg.sv
src/axi_channel_capture.sv
src/axi_stream_subordinate.sv
src/bedrock_mem_endpoint.sv
src/axi_mem_top.sv
dv/axi_mem_chk.sv
dv/axi_mem_tb.sv

/* run.sh */
#!/bin/sh
# Compile and run the AXI memory bridge testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module axi_mem_tb -f flist.f --Mdir obj_dir -o axi_mem_sim

./obj_dir/axi_mem_sim | tee sim.log

if grep -qx "Regression passed" sim.log; then
  echo "Simulation PASS"
else
  echo "Simulation FAIL"
  exit 1
fi

/* src/axi_channel_capture.sv */
// AXI facing stage of the bridge. Captures one write (AW and W, in any order)
// and one read, then sends them one at a time as stream requests. A tie
// between a ready read and a ready write goes to the side that lost the last
// tie. Only one request is in flight. Its response drives B or R.
`timescale 1ns/1ps
`include "axi_mem_cfg.svh"

module axi_channel_capture
  (input                                  clk_i
   , input                                reset_i

   , input        [`AXI_MEM_ADDR_W-1:0]   awaddr_i
   , input        [`AXI_MEM_ID_W-1:0]     awid_i
   , input        [7:0]                   awlen_i
   , input        [2:0]                   awsize_i
   , input                                awvalid_i
   , output logic                         awready_o

   , input        [`AXI_MEM_DATA_W-1:0]   wdata_i
   , input                                wlast_i
   , input                                wvalid_i
   , output logic                         wready_o

   , output logic [`AXI_MEM_ID_W-1:0]     bid_o
   , output logic [1:0]                   bresp_o
   , output logic                         bvalid_o
   , input                                bready_i

   , input        [`AXI_MEM_ADDR_W-1:0]   araddr_i
   , input        [`AXI_MEM_ID_W-1:0]     arid_i
   , input        [7:0]                   arlen_i
   , input        [2:0]                   arsize_i
   , input                                arvalid_i
   , output logic                         arready_o

   , output logic [`AXI_MEM_DATA_W-1:0]   rdata_o
   , output logic [`AXI_MEM_ID_W-1:0]     rid_o
   , output logic [1:0]                   rresp_o
   , output logic                         rlast_o
   , output logic                         rvalid_o
   , input                                rready_i

   , output axi_mem_pkg::axi_req_s        req_o
   , output logic                         req_v_o
   , input                                req_ready_and_i

   , input  axi_mem_pkg::axi_rsp_s        rsp_i
   , input                                rsp_v_i
   , output logic                         rsp_ready_and_o
   );

  axi_mem_pkg::capture_state_e state_q, state_n;
  logic                        live_q;
  logic                        aw_have_q, w_have_q, ar_have_q;
  logic                        last_write_q;
  logic [`AXI_MEM_ADDR_W-1:0]  aw_addr_q, ar_addr_q;
  logic [`AXI_MEM_ID_W-1:0]    aw_id_q, ar_id_q;
  logic [2:0]                  aw_size_q, ar_size_q;
  logic [`AXI_MEM_DATA_W-1:0]  w_data_q;
  logic                        idle, send_write;
  logic                        aw_fire, w_fire, ar_fire, req_fire, rsp_fire;
  logic                        wr_ok, rd_ok;

  assign idle      = live_q & (state_q == axi_mem_pkg::e_idle);
  assign awready_o = idle & ~aw_have_q;
  assign wready_o  = idle & ~w_have_q;
  assign arready_o = idle & ~ar_have_q;

  assign aw_fire  = awvalid_i & awready_o;
  assign w_fire   = wvalid_i & wready_o;
  assign ar_fire  = arvalid_i & arready_o;
  assign req_fire = req_v_o & req_ready_and_i;
  assign rsp_fire = rsp_v_i & rsp_ready_and_o;

  // Count this cycle's handshakes so the request goes out the next cycle.
  assign wr_ok = (aw_have_q | aw_fire) & (w_have_q | w_fire);
  assign rd_ok = ar_have_q | ar_fire;

  always_comb begin
    state_n = state_q;
    case (state_q)
      axi_mem_pkg::e_idle: begin
        if (wr_ok && !(rd_ok && last_write_q)) state_n = axi_mem_pkg::e_fwd_write;
        else if (rd_ok)                        state_n = axi_mem_pkg::e_fwd_read;
      end
      axi_mem_pkg::e_fwd_read,
      axi_mem_pkg::e_fwd_write: if (req_fire) state_n = axi_mem_pkg::e_wait_rev;
      axi_mem_pkg::e_wait_rev:  if (rsp_fire) state_n = axi_mem_pkg::e_idle;
      default:                  state_n = axi_mem_pkg::e_idle;
    endcase
  end

  assign send_write = (state_q == axi_mem_pkg::e_fwd_write);
  assign req_v_o    = send_write | (state_q == axi_mem_pkg::e_fwd_read);

  always_comb begin
    req_o.write = send_write;
    req_o.addr  = send_write ? aw_addr_q : ar_addr_q;
    req_o.size  = send_write ? aw_size_q : ar_size_q;
    req_o.data  = w_data_q;                            // Ignored on reads.
  end

  // Hold a response back while its channel still shows the previous one.
  assign rsp_ready_and_o = (state_q == axi_mem_pkg::e_wait_rev)
                           & (rsp_i.write ? ~bvalid_o : ~rvalid_o);

  assign bresp_o = 2'b00;                              // OKAY.
  assign rresp_o = 2'b00;
  assign rlast_o = 1'b1;                               // Single beat only.

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q      <= axi_mem_pkg::e_idle;
      live_q       <= 1'b0;
      aw_have_q    <= 1'b0;
      w_have_q     <= 1'b0;
      ar_have_q    <= 1'b0;
      last_write_q <= 1'b0;
      bvalid_o     <= 1'b0;
      rvalid_o     <= 1'b0;
    end else begin
      state_q <= state_n;
      live_q  <= 1'b1;
      if (aw_fire)                     aw_have_q <= 1'b1;
      else if (req_fire && send_write) aw_have_q <= 1'b0;
      if (w_fire)                      w_have_q  <= 1'b1;
      else if (req_fire && send_write) w_have_q  <= 1'b0;
      if (ar_fire)                      ar_have_q <= 1'b1;
      else if (req_fire && !send_write) ar_have_q <= 1'b0;
      // Record the tie winner so the other side wins the next tie.
      if (idle && wr_ok && rd_ok) last_write_q <= (state_n == axi_mem_pkg::e_fwd_write);
      if (rsp_fire && rsp_i.write) bvalid_o <= 1'b1;
      else if (bready_i)           bvalid_o <= 1'b0;
      if (rsp_fire && !rsp_i.write) rvalid_o <= 1'b1;
      else if (rready_i)            rvalid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_fire) begin
      aw_addr_q <= awaddr_i;
      aw_id_q   <= awid_i;
      aw_size_q <= awsize_i;
    end
    if (w_fire) w_data_q <= wdata_i;
    if (ar_fire) begin
      ar_addr_q <= araddr_i;
      ar_id_q   <= arid_i;
      ar_size_q <= arsize_i;
    end
    if (rsp_fire && rsp_i.write) bid_o <= aw_id_q;
    if (rsp_fire && !rsp_i.write) begin
      rid_o   <= ar_id_q;
      rdata_o <= rsp_i.data;
    end
  end

endmodule

/* src/axi_mem_cfg.svh */
// Shared widths and sizes for the AXI to uncached memory bridge.
// Include this header in any file that sizes ports or types from these macros.
// The memory endpoint stores 64-bit words, so address bits 10:3 pick a word.
`ifndef AXI_MEM_CFG_SVH
`define AXI_MEM_CFG_SVH

`define AXI_MEM_DATA_W    64   // AXI and stream data width.
`define AXI_MEM_ADDR_W    32   // Byte address width.
`define AXI_MEM_ID_W      2    // AXI transaction id width.
`define AXI_MEM_WORDS     256  // Memory depth in 64-bit words.
`define AXI_MEM_LCE_ID_W  4    // Requester tag copied into forward headers.
`define AXI_MEM_DID_W     3    // Domain tag copied into forward headers.

`endif

/* src/axi_mem_pkg.sv */
// Types shared by the AXI capture stage, the stream subordinate and the
// memory endpoint. Refer to these by scoped name (axi_mem_pkg::name).
// Widths come from the configuration header.
`include "axi_mem_cfg.svh"

package axi_mem_pkg;

  // Uncached message types on the forward and reverse channels.
  typedef enum logic [1:0] {
    e_mem_uc_rd = 2'b00,
    e_mem_uc_wr = 2'b01
  } mem_msg_e;

  // Transfer size, same encoding as AXI awsize/arsize.
  typedef enum logic [2:0] {
    e_size_1 = 3'b000,
    e_size_2 = 3'b001,
    e_size_4 = 3'b010,
    e_size_8 = 3'b011
  } msg_size_e;

  // Arbitration state of the AXI capture stage.
  typedef enum logic [1:0] {
    e_idle      = 2'b00,
    e_fwd_read  = 2'b01,
    e_fwd_write = 2'b10,
    e_wait_rev  = 2'b11
  } capture_state_e;

  // One serialized AXI request.
  typedef struct packed {
    logic                        write;
    logic [`AXI_MEM_ADDR_W-1:0]  addr;
    logic [2:0]                  size;  // AXI size encoding.
    logic [`AXI_MEM_DATA_W-1:0]  data;
  } axi_req_s;

  typedef struct packed {
    mem_msg_e                     msg_type;
    logic [`AXI_MEM_ADDR_W-1:0]   addr;
    msg_size_e                    size;
    logic [`AXI_MEM_LCE_ID_W-1:0] lce_id;
    logic [`AXI_MEM_DID_W-1:0]    did;
  } mem_fwd_header_s;

  // Echo of the forward header.
  typedef struct packed {
    mem_msg_e                     msg_type;
    logic [`AXI_MEM_ADDR_W-1:0]   addr;
    msg_size_e                    size;
    logic [`AXI_MEM_LCE_ID_W-1:0] lce_id;
    logic [`AXI_MEM_DID_W-1:0]    did;
  } mem_rev_header_s;

  // Decoded response back to the capture stage.
  typedef struct packed {
    logic                       write;
    logic [`AXI_MEM_DATA_W-1:0] data;
  } axi_rsp_s;

endpackage

/* src/axi_mem_top.sv */
// Top level of the AXI to uncached memory path. The AXI capture stage feeds
// the stream subordinate, which talks to the memory endpoint. lce_id_i and
// did_i are static tags placed in every forward header.
`timescale 1ns/1ps
`include "axi_mem_cfg.svh"

module axi_mem_top
  (input                                  clk_i
   , input                                reset_i
   , input        [`AXI_MEM_LCE_ID_W-1:0] lce_id_i
   , input        [`AXI_MEM_DID_W-1:0]    did_i

   , input        [`AXI_MEM_ADDR_W-1:0]   awaddr_i
   , input        [`AXI_MEM_ID_W-1:0]     awid_i
   , input        [7:0]                   awlen_i
   , input        [2:0]                   awsize_i
   , input                                awvalid_i
   , output logic                         awready_o

   , input        [`AXI_MEM_DATA_W-1:0]   wdata_i
   , input                                wlast_i
   , input                                wvalid_i
   , output logic                         wready_o

   , output logic [`AXI_MEM_ID_W-1:0]     bid_o
   , output logic [1:0]                   bresp_o
   , output logic                         bvalid_o
   , input                                bready_i

   , input        [`AXI_MEM_ADDR_W-1:0]   araddr_i
   , input        [`AXI_MEM_ID_W-1:0]     arid_i
   , input        [7:0]                   arlen_i
   , input        [2:0]                   arsize_i
   , input                                arvalid_i
   , output logic                         arready_o

   , output logic [`AXI_MEM_DATA_W-1:0]   rdata_o
   , output logic [`AXI_MEM_ID_W-1:0]     rid_o
   , output logic [1:0]                   rresp_o
   , output logic                         rlast_o
   , output logic                         rvalid_o
   , input                                rready_i
   );

  axi_mem_pkg::axi_req_s        req;
  axi_mem_pkg::axi_rsp_s        rsp;
  axi_mem_pkg::mem_fwd_header_s mem_fwd_header;
  axi_mem_pkg::mem_rev_header_s mem_rev_header;
  logic [`AXI_MEM_DATA_W-1:0]   mem_fwd_data, mem_rev_data;
  logic                         req_v, req_ready_and, rsp_v, rsp_ready_and;
  logic                         mem_fwd_v, mem_fwd_ready_and, mem_rev_v, mem_rev_ready_and;

  axi_channel_capture capture
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.awaddr_i(awaddr_i), .awid_i(awid_i), .awlen_i(awlen_i), .awsize_i(awsize_i)
     ,.awvalid_i(awvalid_i), .awready_o(awready_o)
     ,.wdata_i(wdata_i), .wlast_i(wlast_i), .wvalid_i(wvalid_i), .wready_o(wready_o)
     ,.bid_o(bid_o), .bresp_o(bresp_o), .bvalid_o(bvalid_o), .bready_i(bready_i)
     ,.araddr_i(araddr_i), .arid_i(arid_i), .arlen_i(arlen_i), .arsize_i(arsize_i)
     ,.arvalid_i(arvalid_i), .arready_o(arready_o)
     ,.rdata_o(rdata_o), .rid_o(rid_o), .rresp_o(rresp_o), .rlast_o(rlast_o)
     ,.rvalid_o(rvalid_o), .rready_i(rready_i)
     ,.req_o(req), .req_v_o(req_v), .req_ready_and_i(req_ready_and)
     ,.rsp_i(rsp), .rsp_v_i(rsp_v), .rsp_ready_and_o(rsp_ready_and)
     );

  axi_stream_subordinate subordinate
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.lce_id_i(lce_id_i)
     ,.did_i(did_i)
     ,.req_i(req), .req_v_i(req_v), .req_ready_and_o(req_ready_and)
     ,.mem_fwd_header_o(mem_fwd_header), .mem_fwd_data_o(mem_fwd_data)
     ,.mem_fwd_v_o(mem_fwd_v), .mem_fwd_ready_and_i(mem_fwd_ready_and)
     ,.mem_rev_header_i(mem_rev_header), .mem_rev_data_i(mem_rev_data)
     ,.mem_rev_v_i(mem_rev_v), .mem_rev_ready_and_o(mem_rev_ready_and)
     ,.rsp_o(rsp), .rsp_v_o(rsp_v), .rsp_ready_and_i(rsp_ready_and)
     );

  bedrock_mem_endpoint endpoint
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.mem_fwd_header_i(mem_fwd_header), .mem_fwd_data_i(mem_fwd_data)
     ,.mem_fwd_v_i(mem_fwd_v), .mem_fwd_ready_and_o(mem_fwd_ready_and)
     ,.mem_rev_header_o(mem_rev_header), .mem_rev_data_o(mem_rev_data)
     ,.mem_rev_v_o(mem_rev_v), .mem_rev_ready_and_i(mem_rev_ready_and)
     );

endmodule

/* src/axi_stream_subordinate.sv */
// Converts serialized AXI requests into uncached stream messages and decodes
// reverse messages back into read or write responses. Each direction has a
// one-entry output register that can be refilled in the cycle it drains.
`timescale 1ns/1ps
`include "axi_mem_cfg.svh"

module axi_stream_subordinate
  (input                                     clk_i
   , input                                   reset_i

   , input        [`AXI_MEM_LCE_ID_W-1:0]    lce_id_i
   , input        [`AXI_MEM_DID_W-1:0]       did_i

   , input  axi_mem_pkg::axi_req_s           req_i
   , input                                   req_v_i
   , output logic                            req_ready_and_o

   , output axi_mem_pkg::mem_fwd_header_s    mem_fwd_header_o
   , output logic [`AXI_MEM_DATA_W-1:0]      mem_fwd_data_o
   , output logic                            mem_fwd_v_o
   , input                                   mem_fwd_ready_and_i

   , input  axi_mem_pkg::mem_rev_header_s    mem_rev_header_i
   , input        [`AXI_MEM_DATA_W-1:0]      mem_rev_data_i
   , input                                   mem_rev_v_i
   , output logic                            mem_rev_ready_and_o

   , output axi_mem_pkg::axi_rsp_s           rsp_o
   , output logic                            rsp_v_o
   , input                                   rsp_ready_and_i
   );

  axi_mem_pkg::mem_fwd_header_s fwd_header;
  logic                         req_fire, rev_fire;

  always_comb begin
    fwd_header          = '0;
    fwd_header.msg_type = req_i.write ? axi_mem_pkg::e_mem_uc_wr : axi_mem_pkg::e_mem_uc_rd;
    fwd_header.addr     = req_i.addr;
    fwd_header.size     = axi_mem_pkg::msg_size_e'(req_i.size);
    fwd_header.lce_id   = lce_id_i;
    fwd_header.did      = did_i;
  end

  // Ready when empty, or when the held entry leaves this cycle.
  assign req_ready_and_o     = ~mem_fwd_v_o | mem_fwd_ready_and_i;
  assign mem_rev_ready_and_o = ~rsp_v_o | rsp_ready_and_i;
  assign req_fire = req_v_i & req_ready_and_o;
  assign rev_fire = mem_rev_v_i & mem_rev_ready_and_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mem_fwd_v_o <= 1'b0;
      rsp_v_o     <= 1'b0;
    end else begin
      if (req_fire)                 mem_fwd_v_o <= 1'b1;
      else if (mem_fwd_ready_and_i) mem_fwd_v_o <= 1'b0;
      if (rev_fire)             rsp_v_o <= 1'b1;
      else if (rsp_ready_and_i) rsp_v_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      mem_fwd_header_o <= fwd_header;
      mem_fwd_data_o   <= req_i.data;
    end
    if (rev_fire) begin
      rsp_o.write <= (mem_rev_header_i.msg_type == axi_mem_pkg::e_mem_uc_wr);
      rsp_o.data  <= mem_rev_data_i;
    end
  end

endmodule

/* src/bedrock_mem_endpoint.sv */
// Uncached memory endpoint. Accepts one forward message when its response
// register is empty and answers exactly one cycle later, echoing the header.
// Writes merge 2**size bytes at the address offset. Reads return the word.
`timescale 1ns/1ps
`include "axi_mem_cfg.svh"

module bedrock_mem_endpoint
  (input                                     clk_i
   , input                                   reset_i

   , input  axi_mem_pkg::mem_fwd_header_s    mem_fwd_header_i
   , input        [`AXI_MEM_DATA_W-1:0]      mem_fwd_data_i
   , input                                   mem_fwd_v_i
   , output logic                            mem_fwd_ready_and_o

   , output axi_mem_pkg::mem_rev_header_s    mem_rev_header_o
   , output logic [`AXI_MEM_DATA_W-1:0]      mem_rev_data_o
   , output logic                            mem_rev_v_o
   , input                                   mem_rev_ready_and_i
   );

  localparam int idx_w_lp   = $clog2(`AXI_MEM_WORDS);
  localparam int bytes_lp   = `AXI_MEM_DATA_W / 8;

  logic [`AXI_MEM_DATA_W-1:0] mem_q [`AXI_MEM_WORDS];
  logic [idx_w_lp-1:0]        idx;
  logic [bytes_lp-1:0]        lane_mask;
  logic [`AXI_MEM_DATA_W-1:0] merged;
  logic                       fwd_fire, is_wr;

  assign mem_fwd_ready_and_o = ~mem_rev_v_o;
  assign fwd_fire = mem_fwd_v_i & mem_fwd_ready_and_o;
  assign idx      = mem_fwd_header_i.addr[idx_w_lp+2:3];
  assign is_wr    = (mem_fwd_header_i.msg_type == axi_mem_pkg::e_mem_uc_wr);

  // Lanes follow AXI narrow rules: bytes off .. off + 2**size - 1.
  always_comb begin
    lane_mask = bytes_lp'(((16'd1 << (5'd1 << mem_fwd_header_i.size)) - 16'd1)
                          << mem_fwd_header_i.addr[2:0]);
    for (int b = 0; b < bytes_lp; b++) begin
      merged[8*b +: 8] = lane_mask[b] ? mem_fwd_data_i[8*b +: 8] : mem_q[idx][8*b +: 8];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mem_rev_v_o <= 1'b0;
      for (int i = 0; i < `AXI_MEM_WORDS; i++) begin
        mem_q[i] <= '0;
      end
    end else begin
      if (fwd_fire)                 mem_rev_v_o <= 1'b1;
      else if (mem_rev_ready_and_i) mem_rev_v_o <= 1'b0;
      if (fwd_fire && is_wr) mem_q[idx] <= merged;       // Write lands at acceptance.
    end
  end

  always_ff @(posedge clk_i) begin
    if (fwd_fire) begin
      mem_rev_header_o <= axi_mem_pkg::mem_rev_header_s'(mem_fwd_header_i);
      mem_rev_data_o   <= mem_q[idx];                    // Old word on writes.
    end
  end

endmodule
